/* design/pmp_macros.svh */
/* Build-time constants for the PMP checker, which is built at one region count.
   NA4 matching is meaningful only while PMP_G is 0 */

`ifndef PMP_MACROS_SVH
`define PMP_MACROS_SVH

// ----------------------------------------------------------------------
// Region count and granularity
// ----------------------------------------------------------------------
`define PMP_NUM_REGIONS 4
`define PMP_G           0

// Debug module window, inclusive bounds on the 34-bit physical address
`define PMP_DM_START    34'h1_A000_0000
`define PMP_DM_END      34'h1_A000_0FFF

// ----------------------------------------------------------------------
// Bit positions inside a pmpcfg byte
// ----------------------------------------------------------------------
`define PMP_CFG_R       0
`define PMP_CFG_W       1
`define PMP_CFG_X       2
`define PMP_CFG_A_LO    3
`define PMP_CFG_L       7

`endif

/* design/pmp_pkg.sv */
/* Shared types of the PMP checker. Widths of index and vector types
   follow PMP_NUM_REGIONS from the macro header */

`default_nettype none

`include "pmp_macros.svh"

package pmp_pkg;

  // Physical request address and the pmpaddr word (physical bits 33:2)
  typedef logic [33:0] phys_addr_t;
  typedef logic [31:0] pmp_addr_t;

  typedef logic [$clog2(`PMP_NUM_REGIONS)-1:0] region_idx_t;
  typedef logic [`PMP_NUM_REGIONS-1:0]         region_vec_t;
  typedef logic [7:0]                          pmp_cfg_t;

  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'd0,
    PMP_ACC_WRITE = 2'd1,
    PMP_ACC_EXEC  = 2'd2
  } pmp_acc_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // Encoding of the A field
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    CSR_SEL_CFG     = 2'd0,
    CSR_SEL_ADDR    = 2'd1,
    CSR_SEL_MSECCFG = 2'd2
  } csr_sel_e;

endpackage

`default_nettype wire

/* design/pmp_if.sv */
/* Stage-to-stage buses of the checker pipeline. Each carries a one-cycle
   valid pulse and has no stall */

`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------------------------------------
// Front end to match stage
// ----------------------------------------------------------------------
interface pmp_req_if;
  import pmp_pkg::*;

  logic       valid;
  phys_addr_t addr;
  pmp_acc_e   acc;
  priv_lvl_e  priv;
  logic       debug;

  modport source (output valid, addr, acc, priv, debug);
  modport sink   (input  valid, addr, acc, priv, debug);
endinterface

// ----------------------------------------------------------------------
// Match stage to permission stage
// ----------------------------------------------------------------------
interface pmp_match_if;
  import pmp_pkg::*;

  logic        valid;
  region_vec_t match_vec;
  pmp_acc_e    acc;
  priv_lvl_e   priv;
  logic        dm_hit;

  modport source (output valid, match_vec, acc, priv, dm_hit);
  modport sink   (input  valid, match_vec, acc, priv, dm_hit);
endinterface

// ----------------------------------------------------------------------
// Permission stage back to front end
// ----------------------------------------------------------------------
interface pmp_result_if;
  import pmp_pkg::*;

  logic        valid;
  logic        allowed;
  logic        matched;
  region_idx_t region;

  modport source (output valid, allowed, matched, region);
  modport sink   (input  valid, allowed, matched, region);
endinterface

`default_nettype wire

/* design/pmp_csr_file.sv */
/* PMP configuration registers. Writes to a locked entry are dropped until
   reset, and MMWP can only be set. Writes are expected only while idle */

`timescale 1ns/1ps
`default_nettype none

`include "pmp_macros.svh"

module pmp_csr_file (
  input  wire                                           clk,
  input  wire                                           rst_i,
  input  wire                                           csr_we_i,
  input  pmp_pkg::csr_sel_e                             csr_sel_i,
  input  pmp_pkg::region_idx_t                          csr_idx_i,
  input  wire [31:0]                                    csr_wdata_i,
  output pmp_pkg::pmp_cfg_t  [`PMP_NUM_REGIONS-1:0]     cfg_o,
  output pmp_pkg::pmp_addr_t [`PMP_NUM_REGIONS-1:0]     addr_o,
  output logic                                          mmwp_o
);
  import pmp_pkg::*;

  pmp_cfg_t  [`PMP_NUM_REGIONS-1:0] cfg_q;
  pmp_addr_t [`PMP_NUM_REGIONS-1:0] addr_q;
  logic                             mmwp_q;
  logic                             entry_locked;

  // L bit of the addressed entry guards both its cfg byte and its address
  assign entry_locked = cfg_q[csr_idx_i][`PMP_CFG_L];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
      mmwp_q <= 1'b0;
    end else if (csr_we_i) begin
      case (csr_sel_i)
        CSR_SEL_CFG: begin
          if (!entry_locked) begin
            cfg_q[csr_idx_i] <= csr_wdata_i[7:0];
          end
        end
        CSR_SEL_ADDR: begin
          if (!entry_locked) begin
            addr_q[csr_idx_i] <= csr_wdata_i;
          end
        end
        CSR_SEL_MSECCFG: begin
          // Sticky, a zero in bit 1 leaves MMWP as it is
          if (csr_wdata_i[1]) begin
            mmwp_q <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;
  assign mmwp_o = mmwp_q;

endmodule

`default_nettype wire

/* design/pmp_req_frontend.sv */
/* Four-phase req/ack front end, one request in flight at a time.
   Request fields must stay stable until ack_o rises */

`timescale 1ns/1ps
`default_nettype none

module pmp_req_frontend (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   req_i,
  input  pmp_pkg::phys_addr_t   req_addr_i,
  input  pmp_pkg::pmp_acc_e     req_acc_i,
  input  pmp_pkg::priv_lvl_e    req_priv_i,
  input  wire                   req_debug_i,
  output logic                  ack_o,
  output logic                  allowed_o,
  output logic                  matched_o,
  output pmp_pkg::region_idx_t  region_o,
  pmp_req_if.source             req_port,
  pmp_result_if.sink            res_port
);
  import pmp_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT, ACK} fe_state_e;

  fe_state_e state_q;

  // ----------------------------------------------------------------------
  // Handshake FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q        <= IDLE;
      req_port.valid <= 1'b0;
    end else begin
      req_port.valid <= 1'b0;
      case (state_q)
        IDLE: if (req_i) begin
          req_port.valid <= 1'b1;
          state_q        <= WAIT;
        end
        WAIT: if (res_port.valid) state_q <= ACK;
        ACK:  if (!req_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request fields latched at acceptance
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      req_port.addr  <= req_addr_i;
      req_port.acc   <= req_acc_i;
      req_port.priv  <= req_priv_i;
      req_port.debug <= req_debug_i;
    end
  end

  // Result held for the whole ack phase
  always_ff @(posedge clk) begin
    if (state_q == WAIT && res_port.valid) begin
      allowed_o <= res_port.allowed;
      matched_o <= res_port.matched;
      region_o  <= res_port.region;
    end
  end

  assign ack_o = (state_q == ACK);

endmodule

`default_nettype wire

/* design/pmp_region_match.sv */
/* Stage 1 of the checker, one cycle of latency. Produces one match bit per
   region for TOR, NA4 and NAPOT, plus the debug window hit */

`timescale 1ns/1ps
`default_nettype none

`include "pmp_macros.svh"

module pmp_region_match (
  input  wire                                        clk,
  input  wire                                        rst_i,
  input  pmp_pkg::pmp_cfg_t  [`PMP_NUM_REGIONS-1:0]  cfg_i,
  input  pmp_pkg::pmp_addr_t [`PMP_NUM_REGIONS-1:0]  addr_i,
  pmp_req_if.sink                                    req_port,
  pmp_match_if.source                                match_port
);
  import pmp_pkg::*;

  pmp_addr_t   req_word;
  region_vec_t match_vec;
  logic        dm_hit;

  // NAPOT mask clears every bit up to and including the lowest zero
  function automatic pmp_addr_t napot_mask(input pmp_addr_t a);
    pmp_addr_t base;
    pmp_addr_t mask;
    logic      done;
    base = a;
    mask = '1;
    done = 1'b0;
    for (int j = 0; j < `PMP_G - 1; j++) begin
      base[j] = 1'b1;
    end
    for (int j = 0; j < 32; j++) begin
      if (!done) begin
        mask[j] = 1'b0;
        if (!base[j]) done = 1'b1;
      end
    end
    return mask;
  endfunction

  assign req_word = req_port.addr[33:2];

  // ----------------------------------------------------------------------
  // Per-region match
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : g_region
    pmp_addr_t lo_bound;
    pmp_addr_t mask;
    pmp_mode_e mode;
    logic      tor_hit;
    logic      na4_hit;
    logic      napot_hit;

    // Region 0 uses address zero as its TOR base
    if (i == 0) begin : g_first
      assign lo_bound = '0;
    end else begin : g_rest
      assign lo_bound = addr_i[i-1];
    end

    assign mode      = pmp_mode_e'(cfg_i[i][`PMP_CFG_A_LO +: 2]);
    assign mask      = napot_mask(addr_i[i]);
    assign tor_hit   = (lo_bound[31:`PMP_G] <= req_word[31:`PMP_G]) &&
                       (req_word[31:`PMP_G] <  addr_i[i][31:`PMP_G]);
    assign na4_hit   = (req_word == addr_i[i]);
    assign napot_hit = ((req_word & mask) == (addr_i[i] & mask));

    assign match_vec[i] = (mode == PMP_MODE_TOR   && tor_hit) ||
                          (mode == PMP_MODE_NA4   && na4_hit) ||
                          (mode == PMP_MODE_NAPOT && napot_hit);
  end

  assign dm_hit = req_port.debug &&
                  (req_port.addr >= `PMP_DM_START) && (req_port.addr <= `PMP_DM_END);

  always_ff @(posedge clk) begin
    if (rst_i) match_port.valid <= 1'b0;
    else       match_port.valid <= req_port.valid;
  end

  always_ff @(posedge clk) begin
    if (req_port.valid) begin
      match_port.match_vec <= match_vec;
      match_port.acc       <= req_port.acc;
      match_port.priv      <= req_port.priv;
      match_port.dm_hit    <= dm_hit;
    end
  end

endmodule

`default_nettype wire

/* design/pmp_perm_check.sv */
/* Stage 2 of the checker, one cycle of latency. Legacy permission rules only,
   no MML. Lowest matching index wins and region reads 0 with no match */

`timescale 1ns/1ps
`default_nettype none

`include "pmp_macros.svh"

module pmp_perm_check (
  input  wire                                        clk,
  input  wire                                        rst_i,
  input  pmp_pkg::pmp_cfg_t  [`PMP_NUM_REGIONS-1:0]  cfg_i,
  input  wire                                        mmwp_i,
  pmp_match_if.sink                                  match_port,
  pmp_result_if.source                               res_port
);
  import pmp_pkg::*;

  region_idx_t win_idx;
  pmp_cfg_t    win_cfg;
  logic        matched;
  logic        perm_ok;
  logic        allowed;

  // Priority encoder, scanned from the top so the lowest set bit remains
  always_comb begin
    win_idx = '0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_port.match_vec[i]) win_idx = region_idx_t'(i);
    end
  end

  assign matched = |match_port.match_vec;
  assign win_cfg = cfg_i[win_idx];

  always_comb begin
    case (match_port.acc)
      PMP_ACC_READ:  perm_ok = win_cfg[`PMP_CFG_R];
      PMP_ACC_WRITE: perm_ok = win_cfg[`PMP_CFG_W];
      PMP_ACC_EXEC:  perm_ok = win_cfg[`PMP_CFG_X];
      default:       perm_ok = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Access decision
  // ----------------------------------------------------------------------
  always_comb begin
    if (matched) begin
      // M-mode is bound by the RWX bits only once the entry is locked
      if (match_port.priv == PRIV_LVL_M) begin
        allowed = win_cfg[`PMP_CFG_L] ? perm_ok : 1'b1;
      end else begin
        allowed = perm_ok;
      end
    end else begin
      allowed = (match_port.priv == PRIV_LVL_M) && !mmwp_i;
    end
    // Debug module window overrides any denial
    if (match_port.dm_hit) allowed = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_i) res_port.valid <= 1'b0;
    else       res_port.valid <= match_port.valid;
  end

  always_ff @(posedge clk) begin
    if (match_port.valid) begin
      res_port.allowed <= allowed;
      res_port.matched <= matched;
      res_port.region  <= matched ? win_idx : '0;
    end
  end

endmodule

`default_nettype wire

/* design/pmp_checker_top.sv */
/* PMP access checker top level. ack_o rises 3 cycles after req_i is first
   sampled high; configuration writes only while req_i and ack_o are low */

`timescale 1ns/1ps
`default_nettype none

`include "pmp_macros.svh"

module pmp_checker_top (
  input  wire                   clk,
  input  wire                   rst_i,
  // Configuration port
  input  wire                   csr_we_i,
  input  pmp_pkg::csr_sel_e     csr_sel_i,
  input  pmp_pkg::region_idx_t  csr_idx_i,
  input  wire [31:0]            csr_wdata_i,
  // Request port
  input  wire                   req_i,
  input  pmp_pkg::phys_addr_t   req_addr_i,
  input  pmp_pkg::pmp_acc_e     req_acc_i,
  input  pmp_pkg::priv_lvl_e    req_priv_i,
  input  wire                   req_debug_i,
  // Response port
  output logic                  ack_o,
  output logic                  allowed_o,
  output logic                  matched_o,
  output pmp_pkg::region_idx_t  region_o
);
  import pmp_pkg::*;

  pmp_cfg_t  [`PMP_NUM_REGIONS-1:0] cfg;
  pmp_addr_t [`PMP_NUM_REGIONS-1:0] addr;
  logic                             mmwp;

  pmp_req_if    req_bus ();
  pmp_match_if  match_bus ();
  pmp_result_if res_bus ();

  pmp_csr_file u_csr_file (
    .clk         (clk),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .cfg_o       (cfg),
    .addr_o      (addr),
    .mmwp_o      (mmwp)
  );

  pmp_req_frontend u_frontend (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_addr_i  (req_addr_i),
    .req_acc_i   (req_acc_i),
    .req_priv_i  (req_priv_i),
    .req_debug_i (req_debug_i),
    .ack_o       (ack_o),
    .allowed_o   (allowed_o),
    .matched_o   (matched_o),
    .region_o    (region_o),
    .req_port    (req_bus.source),
    .res_port    (res_bus.sink)
  );

  pmp_region_match u_region_match (
    .clk        (clk),
    .rst_i      (rst_i),
    .cfg_i      (cfg),
    .addr_i     (addr),
    .req_port   (req_bus.sink),
    .match_port (match_bus.source)
  );

  pmp_perm_check u_perm_check (
    .clk        (clk),
    .rst_i      (rst_i),
    .cfg_i      (cfg),
    .mmwp_i     (mmwp),
    .match_port (match_bus.sink),
    .res_port   (res_bus.source)
  );

endmodule

`default_nettype wire

/* verif/pmp_checker_props.sv */
/* Handshake and result stability properties, bound to the checker top level.
   Assumes the requester holds req_i high until it sees ack_o */

`timescale 1ns/1ps
`default_nettype none

module pmp_checker_props (
  input wire                  clk,
  input wire                  rst_i,
  input wire                  req_i,
  input wire                  ack_o,
  input wire                  allowed_o,
  input wire                  matched_o,
  input pmp_pkg::region_idx_t region_o
);

  // ack_o only rises while a request is pending
  assert property (@(posedge clk) disable iff (rst_i) $rose(ack_o) |-> req_i)
    else $error("ack_o rose while req_i was low");

  // Once acknowledged, ack_o holds until the requester lets go
  assert property (@(posedge clk) disable iff (rst_i) (ack_o && req_i) |=> ack_o)
    else $error("ack_o dropped while req_i was still high");

  assert property (@(posedge clk) disable iff (rst_i)
                   (ack_o && $past(ack_o)) |-> $stable({allowed_o, matched_o, region_o}))
    else $error("result outputs changed while ack_o was high");

endmodule

`default_nettype wire

/* verif/pmp_checker_tb.sv */
/* Directed testbench for the PMP checker. Expected results come from a
   behavioural model of the PMP rules kept in step with every CSR write */

`timescale 1ns/1ps
`default_nettype none

`include "pmp_macros.svh"

module pmp_checker_tb;
  import pmp_pkg::*;

  // About 40 accesses of 8 cycles plus CSR writes and reset, with margin
  localparam int CYCLE_LIMIT = 3000;
  localparam int ACK_WAIT    = 10;

  logic        clk;
  logic        rst_i;
  logic        csr_we_i;
  csr_sel_e    csr_sel_i;
  region_idx_t csr_idx_i;
  logic [31:0] csr_wdata_i;
  logic        req_i;
  phys_addr_t  req_addr_i;
  pmp_acc_e    req_acc_i;
  priv_lvl_e   req_priv_i;
  logic        req_debug_i;
  logic        ack_o;
  logic        allowed_o;
  logic        matched_o;
  region_idx_t region_o;

  // Reference copy of the CSR state
  pmp_cfg_t    model_cfg  [`PMP_NUM_REGIONS];
  pmp_addr_t   model_addr [`PMP_NUM_REGIONS];
  logic        model_mmwp;

  int          checks;
  int          errors;
  int          cycle_cnt;
  string       test_name;

  pmp_checker_top dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .req_i       (req_i),
    .req_addr_i  (req_addr_i),
    .req_acc_i   (req_acc_i),
    .req_priv_i  (req_priv_i),
    .req_debug_i (req_debug_i),
    .ack_o       (ack_o),
    .allowed_o   (allowed_o),
    .matched_o   (matched_o),
    .region_o    (region_o)
  );

  bind pmp_checker_top pmp_checker_props u_props (
    .clk       (clk),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .ack_o     (ack_o),
    .allowed_o (allowed_o),
    .matched_o (matched_o),
    .region_o  (region_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model of the PMP rules
  // ----------------------------------------------------------------------
  function automatic logic region_hit(input int i, input pmp_addr_t word);
    pmp_addr_t lo;
    int        ones;
    lo = '0;
    if (i > 0) lo = model_addr[i-1];
    // NAPOT size follows the run of trailing ones in pmpaddr
    ones = 0;
    while (ones < 32 && model_addr[i][ones]) ones++;
    case (model_cfg[i][`PMP_CFG_A_LO +: 2])
      2'd1:    return (word >= lo) && (word < model_addr[i]);
      2'd2:    return word == model_addr[i];
      2'd3:    return (64'(word) >> (ones + 1)) == (64'(model_addr[i]) >> (ones + 1));
      default: return 1'b0;
    endcase
  endfunction

  task automatic predict(input phys_addr_t a, input pmp_acc_e acc, input priv_lvl_e priv,
                         input logic dbg, output logic exp_allowed,
                         output logic exp_matched, output region_idx_t exp_region);
    pmp_cfg_t c;
    logic     perm;
    exp_matched = 1'b0;
    exp_region  = '0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (!exp_matched && region_hit(i, a[33:2])) begin
        exp_matched = 1'b1;
        exp_region  = region_idx_t'(i);
      end
    end
    c    = model_cfg[exp_region];
    perm = (acc == PMP_ACC_READ)  ? c[`PMP_CFG_R] :
           (acc == PMP_ACC_WRITE) ? c[`PMP_CFG_W] : c[`PMP_CFG_X];
    if (!exp_matched) exp_allowed = (priv == PRIV_LVL_M) && !model_mmwp;
    else if (priv == PRIV_LVL_M) exp_allowed = c[`PMP_CFG_L] ? perm : 1'b1;
    else exp_allowed = perm;
    if (dbg && a >= `PMP_DM_START && a <= `PMP_DM_END) exp_allowed = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // Bus tasks and checker
  // ----------------------------------------------------------------------
  task automatic check(input string what, input logic [33:0] expected,
                       input logic [33:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic csr_write(input csr_sel_e sel, input region_idx_t idx, input logic [31:0] data);
    @(posedge clk);
    #2;
    csr_we_i    = 1'b1;
    csr_sel_i   = sel;
    csr_idx_i   = idx;
    csr_wdata_i = data;
    @(posedge clk);
    #2;
    csr_we_i = 1'b0;
    // Locked entries keep cfg and address, MMWP only ever sets
    if (sel == CSR_SEL_CFG && !model_cfg[idx][`PMP_CFG_L]) model_cfg[idx] = data[7:0];
    if (sel == CSR_SEL_ADDR && !model_cfg[idx][`PMP_CFG_L]) model_addr[idx] = data;
    if (sel == CSR_SEL_MSECCFG && data[1]) model_mmwp = 1'b1;
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (ack_o !== level && cycles < ACK_WAIT);
    if (ack_o !== level) begin
      errors++;
      $display("Error in %s: ack_o did not go to %0b within %0d cycles",
               test_name, level, ACK_WAIT);
    end
  endtask

  task automatic do_access(input phys_addr_t a, input pmp_acc_e acc,
                           input priv_lvl_e priv, input logic dbg);
    logic        exp_allowed;
    logic        exp_matched;
    region_idx_t exp_region;
    predict(a, acc, priv, dbg, exp_allowed, exp_matched, exp_region);
    @(posedge clk);
    #2;
    req_i       = 1'b1;
    req_addr_i  = a;
    req_acc_i   = acc;
    req_priv_i  = priv;
    req_debug_i = dbg;
    wait_ack(1'b1);
    check($sformatf("allowed @%h", a), exp_allowed, allowed_o);
    check($sformatf("matched @%h", a), exp_matched, matched_o);
    check($sformatf("region @%h", a), exp_region, region_o);
    @(posedge clk);
    #2;
    req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic report_test(input int err_start);
    $display("Test %s finished with %0d errors", test_name, errors - err_start);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset_defaults();
    int err_start;
    err_start = errors;
    test_name = "reset_defaults";
    @(negedge clk);
    check("ack_o", 1'b0, ack_o);
    do_access(34'h0_0000_1000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    do_access(34'h0_0000_1000, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    report_test(err_start);
  endtask

  task automatic test_handshake();
    int err_start;
    err_start = errors;
    test_name = "handshake";
    @(posedge clk);
    #2;
    req_i      = 1'b1;
    req_addr_i = 34'h0_0000_2000;
    req_acc_i  = PMP_ACC_READ;
    req_priv_i = PRIV_LVL_M;
    // Front end samples req_i at this edge
    @(posedge clk);
    for (int k = 1; k <= 3; k++) begin
      @(posedge clk);
      @(negedge clk);
      check($sformatf("ack after %0d cycles", k), (k == 3), ack_o);
    end
    repeat (5) begin
      @(negedge clk);
      check("ack held", 1'b1, ack_o);
    end
    @(posedge clk);
    #2;
    req_i = 1'b0;
    // The next edge sees req_i low and ends the ack phase
    @(posedge clk);
    @(negedge clk);
    check("ack fall", 1'b0, ack_o);
    report_test(err_start);
  endtask

  task automatic test_matching();
    int         err_start;
    phys_addr_t a;
    err_start = errors;
    test_name = "matching";
    csr_write(CSR_SEL_ADDR, 0, 32'h0000_4000);
    csr_write(CSR_SEL_CFG,  0, 32'h09);
    csr_write(CSR_SEL_ADDR, 1, 32'h2000_0004);
    csr_write(CSR_SEL_CFG,  1, 32'h13);
    csr_write(CSR_SEL_ADDR, 2, 32'h2000_01FF);
    csr_write(CSR_SEL_CFG,  2, 32'h1D);
    // Region edges first
    do_access(34'h0_0000_FFFC, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    do_access(34'h0_0001_0000, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    do_access(34'h0_8000_0010, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    do_access(34'h0_8000_0FFC, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0);
    do_access(34'h0_8000_1000, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    repeat (20) begin
      case ($urandom % 4)
        0: a = 34'($urandom % 32'h0001_0000);
        1: a = 34'h0_8000_0010 + 34'($urandom % 4);
        2: a = 34'h0_8000_0000 + 34'($urandom % 32'h1000);
        default: begin
          a[33:32] = 2'($urandom);
          a[31:0]  = $urandom;
        end
      endcase
      do_access(a, pmp_acc_e'($urandom % 3), ($urandom % 2) ? PRIV_LVL_M : PRIV_LVL_U, 1'b0);
    end
    report_test(err_start);
  endtask

  task automatic test_permissions();
    int err_start;
    err_start = errors;
    test_name = "permissions";
    csr_write(CSR_SEL_ADDR, 3, 32'h1000_01FF);
    csr_write(CSR_SEL_CFG,  3, 32'h19);
    do_access(34'h0_4000_0100, PMP_ACC_READ,  PRIV_LVL_U, 1'b0);
    do_access(34'h0_4000_0100, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    do_access(34'h0_4000_0100, PMP_ACC_EXEC,  PRIV_LVL_U, 1'b0);
    do_access(34'h0_4000_0100, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    // Lock the entry, M-mode now follows RWX
    csr_write(CSR_SEL_CFG, 3, 32'h99);
    do_access(34'h0_4000_0100, PMP_ACC_READ,  PRIV_LVL_M, 1'b0);
    do_access(34'h0_4000_0100, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    do_access(34'h0_4000_0100, PMP_ACC_EXEC,  PRIV_LVL_M, 1'b0);
    csr_write(CSR_SEL_CFG,  3, 32'h1F);
    csr_write(CSR_SEL_ADDR, 3, 32'h0000_0000);
    do_access(34'h0_4000_0100, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    do_access(34'h0_4000_0100, PMP_ACC_READ,  PRIV_LVL_U, 1'b0);
    report_test(err_start);
  endtask

  task automatic test_mmwp_debug();
    int err_start;
    err_start = errors;
    test_name = "mmwp_debug";
    do_access(34'h3_0000_0000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    csr_write(CSR_SEL_MSECCFG, 0, 32'h2);
    do_access(34'h3_0000_0000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    csr_write(CSR_SEL_MSECCFG, 0, 32'h0);
    do_access(34'h3_0000_0000, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    do_access(34'h1_A000_0100, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    do_access(34'h1_A000_0100, PMP_ACC_READ, PRIV_LVL_M, 1'b1);
    do_access(34'h1_A000_0100, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1);
    do_access(34'h1_A000_1000, PMP_ACC_READ, PRIV_LVL_M, 1'b1);
    report_test(err_start);
  endtask

  initial begin
    void'($urandom(14));
    clk         = 1'b0;
    rst_i       = 1'b1;
    csr_we_i    = 1'b0;
    csr_sel_i   = CSR_SEL_CFG;
    csr_idx_i   = '0;
    csr_wdata_i = '0;
    req_i       = 1'b0;
    req_addr_i  = '0;
    req_acc_i   = PMP_ACC_READ;
    req_priv_i  = PRIV_LVL_M;
    req_debug_i = 1'b0;
    model_mmwp  = 1'b0;
    checks      = 0;
    errors      = 0;
    cycle_cnt   = 0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      model_cfg[i]  = '0;
      model_addr[i] = '0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_i = 1'b0;
    test_reset_defaults();
    test_handshake();
    test_matching();
    test_permissions();
    test_mmwp_debug();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/pmp_pkg.sv
design/pmp_if.sv
design/pmp_csr_file.sv
design/pmp_req_frontend.sv
design/pmp_region_match.sv
design/pmp_perm_check.sv
design/pmp_checker_top.sv
verif/pmp_checker_props.sv
verif/pmp_checker_tb.sv
